//--- src/fabric_pkg.sv
package fabric_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY = 2'd0;

    // CLINT window and register offsets inside it
    localparam addr_t       CLINT_BASE   = 32'h0200_0000;
    localparam addr_t       CLINT_MASK   = 32'hFFFF_0000;
    localparam logic [15:0] MTIMECMP_OFS = 16'h4000;
    localparam logic [15:0] MTIME_OFS    = 16'hBFF8;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_t;

endpackage

//--- src/rd_bus_if.sv
`timescale 1ns/1ps

interface rd_bus_if import fabric_pkg::*; ();

    logic  arvalid, arready;
    addr_t araddr;
    logic  rvalid, rready;
    data_t rdata;
    resp_t rresp;

    modport requester (
        output arvalid, araddr, rready,
        input  arready, rvalid, rdata, rresp
    );

    modport target (
        input  arvalid, araddr, rready,
        output arready, rvalid, rdata, rresp
    );

endinterface

//--- src/wr_bus_if.sv
`timescale 1ns/1ps

interface wr_bus_if import fabric_pkg::*; ();

    logic  awvalid, awready;
    addr_t awaddr;
    logic  wvalid, wready;
    data_t wdata;
    strb_t wstrb;
    logic  bvalid, bready;
    resp_t bresp;

    modport requester (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready,
        input  awready, wready, bvalid, bresp
    );

    modport target (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
        output awready, wready, bvalid, bresp
    );

endinterface

//--- src/read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter import fabric_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    rd_bus_if.target    fetch,
    rd_bus_if.target    data,
    rd_bus_if.requester shared
);

    arb_state_t state;
    logic       ar_done;
    logic       own_data;
    logic       own_fetch;
    logic       pick_data;
    logic       pick_fetch;
    logic       r_hs;

    assign own_data  = (state == ARB_DATA);
    assign own_fetch = (state == ARB_FETCH);

    // Data wins a tie in idle, after that the grant stays locked
    assign pick_data  = own_data || (state == ARB_IDLE && data.arvalid);
    assign pick_fetch = own_fetch || (state == ARB_IDLE && !data.arvalid && fetch.arvalid);

    // AR of the owner goes straight through until it is accepted
    assign shared.arvalid = !ar_done &&
                            ((pick_data && data.arvalid) || (pick_fetch && fetch.arvalid));
    assign shared.araddr  = pick_data ? data.araddr : fetch.araddr;
    assign data.arready   = pick_data && !ar_done && shared.arready;
    assign fetch.arready  = pick_fetch && !ar_done && shared.arready;

    // R only reaches the owner
    assign shared.rready = (own_data && data.rready) || (own_fetch && fetch.rready);
    assign data.rvalid   = own_data && shared.rvalid;
    assign fetch.rvalid  = own_fetch && shared.rvalid;
    assign data.rdata    = shared.rdata;
    assign fetch.rdata   = shared.rdata;
    assign data.rresp    = shared.rresp;
    assign fetch.rresp   = shared.rresp;

    assign r_hs = shared.rvalid && shared.rready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= ARB_IDLE;
            ar_done <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_data) begin
                        state <= ARB_DATA;
                    end else if (pick_fetch) begin
                        state <= ARB_FETCH;
                    end
                end
                default: begin
                    if (r_hs) begin
                        state <= ARB_IDLE;
                    end
                end
            endcase

            if (r_hs) begin
                ar_done <= 1'b0;
            end else if (shared.arvalid && shared.arready) begin
                ar_done <= 1'b1;
            end
        end
    end

endmodule

//--- src/addr_router.sv
`timescale 1ns/1ps

module addr_router import fabric_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    rd_bus_if.target    rd_in,
    wr_bus_if.target    wr_in,
    rd_bus_if.requester rd_clint,
    wr_bus_if.requester wr_clint,
    rd_bus_if.requester rd_ext,
    wr_bus_if.requester wr_ext
);

    logic rd_hit;
    logic wr_hit;
    logic rd_to_clint;
    logic wr_to_clint;
    logic aw_open;
    logic w_go;
    logic w_to_clint;

    assign rd_hit = (rd_in.araddr & CLINT_MASK) == CLINT_BASE;
    assign wr_hit = (wr_in.awaddr & CLINT_MASK) == CLINT_BASE;

    assign rd_clint.arvalid = rd_in.arvalid && rd_hit;
    assign rd_ext.arvalid   = rd_in.arvalid && !rd_hit;
    assign rd_clint.araddr  = rd_in.araddr;
    assign rd_ext.araddr    = rd_in.araddr;
    assign rd_in.arready    = rd_hit ? rd_clint.arready : rd_ext.arready;

    // Read response follows the target recorded at the AR handshake
    assign rd_in.rvalid    = rd_to_clint ? rd_clint.rvalid : rd_ext.rvalid;
    assign rd_in.rdata     = rd_to_clint ? rd_clint.rdata : rd_ext.rdata;
    assign rd_in.rresp     = rd_to_clint ? rd_clint.rresp : rd_ext.rresp;
    assign rd_clint.rready = rd_in.rready && rd_to_clint;
    assign rd_ext.rready   = rd_in.rready && !rd_to_clint;

    // No new AW until B of the open write is back
    assign wr_clint.awvalid = wr_in.awvalid && !aw_open && wr_hit;
    assign wr_ext.awvalid   = wr_in.awvalid && !aw_open && !wr_hit;
    assign wr_clint.awaddr  = wr_in.awaddr;
    assign wr_ext.awaddr    = wr_in.awaddr;
    assign wr_in.awready    = !aw_open && (wr_hit ? wr_clint.awready : wr_ext.awready);

    // W waits until its target is known from AW
    assign w_go       = aw_open || wr_in.awvalid;
    assign w_to_clint = aw_open ? wr_to_clint : wr_hit;

    assign wr_clint.wvalid = wr_in.wvalid && w_go && w_to_clint;
    assign wr_ext.wvalid   = wr_in.wvalid && w_go && !w_to_clint;
    assign wr_clint.wdata  = wr_in.wdata;
    assign wr_ext.wdata    = wr_in.wdata;
    assign wr_clint.wstrb  = wr_in.wstrb;
    assign wr_ext.wstrb    = wr_in.wstrb;
    assign wr_in.wready    = w_go && (w_to_clint ? wr_clint.wready : wr_ext.wready);

    assign wr_in.bvalid    = wr_to_clint ? wr_clint.bvalid : wr_ext.bvalid;
    assign wr_in.bresp     = wr_to_clint ? wr_clint.bresp : wr_ext.bresp;
    assign wr_clint.bready = wr_in.bready && wr_to_clint;
    assign wr_ext.bready   = wr_in.bready && !wr_to_clint;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_to_clint <= 1'b0;
            wr_to_clint <= 1'b0;
            aw_open     <= 1'b0;
        end else begin
            if (rd_in.arvalid && rd_in.arready) begin
                rd_to_clint <= rd_hit;
            end
            if (wr_in.awvalid && wr_in.awready) begin
                wr_to_clint <= wr_hit;
                aw_open     <= 1'b1;
            end else if (wr_in.bvalid && wr_in.bready) begin
                aw_open <= 1'b0;
            end
        end
    end

endmodule

//--- src/clint_timer.sv
`timescale 1ns/1ps

module clint_timer import fabric_pkg::*; #(
    parameter int TICK_DIV = 1
) (
    input  logic     clock,
    input  logic     reset,
    rd_bus_if.target rd,
    wr_bus_if.target wr,
    output logic     timer_irq
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    data_t            mtime;
    data_t            mtimecmp;
    logic             port_en;
    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             aw_got;
    logic             w_got;
    logic [15:0]      aw_ofs;
    data_t            w_data;
    strb_t            w_strb;
    logic             do_write;
    logic [15:0]      wr_ofs;
    data_t            wr_data;
    strb_t            wr_strb;

    function automatic data_t merge_bytes(data_t old_val, data_t new_val, strb_t strb);
        data_t res;
        res = old_val;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

    // Ports stay closed while in reset
    assign rd.arready = port_en && !rd.rvalid;
    assign wr.awready = port_en && !aw_got && !wr.bvalid;
    assign wr.wready  = port_en && !w_got && !wr.bvalid;
    assign rd.rresp   = RESP_OKAY;
    assign wr.bresp   = RESP_OKAY;

    assign ar_hs = rd.arvalid && rd.arready;
    assign aw_hs = wr.awvalid && wr.awready;
    assign w_hs  = wr.wvalid && wr.wready;

    // AW and W in either order, the write lands once both are in
    assign do_write = (aw_got || aw_hs) && (w_got || w_hs);
    assign wr_ofs   = aw_got ? aw_ofs : wr.awaddr[15:0];
    assign wr_data  = w_got ? w_data : wr.wdata;
    assign wr_strb  = w_got ? w_strb : wr.wstrb;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            port_en   <= 1'b0;
            div_cnt   <= '0;
            mtime     <= '0;
            mtimecmp  <= '1;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            rd.rvalid <= 1'b0;
            wr.bvalid <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            port_en <= 1'b1;
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (do_write && wr_ofs == MTIME_OFS) begin
                mtime <= merge_bytes(mtime, wr_data, wr_strb);
            end else if (tick) begin
                mtime <= mtime + 64'd1;
            end
            if (do_write && wr_ofs == MTIMECMP_OFS) begin
                mtimecmp <= merge_bytes(mtimecmp, wr_data, wr_strb);
            end
            timer_irq <= (mtime >= mtimecmp);
            aw_got    <= (aw_got || aw_hs) && !do_write;
            w_got     <= (w_got || w_hs) && !do_write;
            if (ar_hs) begin
                rd.rvalid <= 1'b1;
            end else if (rd.rready) begin
                rd.rvalid <= 1'b0;
            end
            if (do_write) begin
                wr.bvalid <= 1'b1;
            end else if (wr.bready) begin
                wr.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_ofs <= wr.awaddr[15:0];
        end
        if (w_hs) begin
            w_data <= wr.wdata;
            w_strb <= wr.wstrb;
        end
        if (ar_hs) begin
            case (rd.araddr[15:0])
                MTIME_OFS:    rd.rdata <= mtime;
                MTIMECMP_OFS: rd.rdata <= mtimecmp;
                default:      rd.rdata <= '0;
            endcase
        end
    end

endmodule

//--- src/fabric_top.sv
`timescale 1ns/1ps

module fabric_top import fabric_pkg::*; #(
    parameter int TICK_DIV = 1
) (
    input  logic  clock,
    input  logic  reset,
    output logic  timer_irq,
    // Fetch read port
    input  logic  fetch_arvalid, fetch_rready,
    input  addr_t fetch_araddr,
    output logic  fetch_arready, fetch_rvalid,
    output data_t fetch_rdata,
    output resp_t fetch_rresp,
    // Data read and write port
    input  logic  data_arvalid, data_rready,
    input  addr_t data_araddr,
    output logic  data_arready, data_rvalid,
    output data_t data_rdata,
    output resp_t data_rresp,
    input  logic  data_awvalid, data_wvalid, data_bready,
    input  addr_t data_awaddr,
    input  data_t data_wdata,
    input  strb_t data_wstrb,
    output logic  data_awready, data_wready, data_bvalid,
    output resp_t data_bresp,
    // External master bus
    input  logic  mem_arready, mem_rvalid, mem_awready, mem_wready, mem_bvalid,
    input  data_t mem_rdata,
    input  resp_t mem_rresp, mem_bresp,
    output logic  mem_arvalid, mem_rready, mem_awvalid, mem_wvalid, mem_bready,
    output addr_t mem_araddr, mem_awaddr,
    output data_t mem_wdata,
    output strb_t mem_wstrb
);

    logic rst_meta;
    logic rst_sync;

    rd_bus_if rd_fetch ();
    rd_bus_if rd_data ();
    rd_bus_if rd_shared ();
    rd_bus_if rd_clint ();
    rd_bus_if rd_ext ();
    wr_bus_if wr_data ();
    wr_bus_if wr_clint ();
    wr_bus_if wr_ext ();

    // Async assert, release after two edges
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rst_meta <= 1'b1;
            rst_sync <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            rst_sync <= rst_meta;
        end
    end

    assign rd_fetch.arvalid = fetch_arvalid;
    assign rd_fetch.araddr  = fetch_araddr;
    assign rd_fetch.rready  = fetch_rready;
    assign fetch_arready    = rd_fetch.arready;
    assign fetch_rvalid     = rd_fetch.rvalid;
    assign fetch_rdata      = rd_fetch.rdata;
    assign fetch_rresp      = rd_fetch.rresp;

    assign rd_data.arvalid = data_arvalid;
    assign rd_data.araddr  = data_araddr;
    assign rd_data.rready  = data_rready;
    assign data_arready    = rd_data.arready;
    assign data_rvalid     = rd_data.rvalid;
    assign data_rdata      = rd_data.rdata;
    assign data_rresp      = rd_data.rresp;

    assign wr_data.awvalid = data_awvalid;
    assign wr_data.awaddr  = data_awaddr;
    assign wr_data.wvalid  = data_wvalid;
    assign wr_data.wdata   = data_wdata;
    assign wr_data.wstrb   = data_wstrb;
    assign wr_data.bready  = data_bready;
    assign data_awready    = wr_data.awready;
    assign data_wready     = wr_data.wready;
    assign data_bvalid     = wr_data.bvalid;
    assign data_bresp      = wr_data.bresp;

    assign mem_arvalid    = rd_ext.arvalid;
    assign mem_araddr     = rd_ext.araddr;
    assign mem_rready     = rd_ext.rready;
    assign rd_ext.arready = mem_arready;
    assign rd_ext.rvalid  = mem_rvalid;
    assign rd_ext.rdata   = mem_rdata;
    assign rd_ext.rresp   = mem_rresp;
    assign mem_awvalid    = wr_ext.awvalid;
    assign mem_awaddr     = wr_ext.awaddr;
    assign mem_wvalid     = wr_ext.wvalid;
    assign mem_wdata      = wr_ext.wdata;
    assign mem_wstrb      = wr_ext.wstrb;
    assign mem_bready     = wr_ext.bready;
    assign wr_ext.awready = mem_awready;
    assign wr_ext.wready  = mem_wready;
    assign wr_ext.bvalid  = mem_bvalid;
    assign wr_ext.bresp   = mem_bresp;

    read_arbiter i_read_arbiter (
        .clock  (clock),
        .reset  (rst_sync),
        .fetch  (rd_fetch),
        .data   (rd_data),
        .shared (rd_shared)
    );

    addr_router i_addr_router (
        .clock    (clock),
        .reset    (rst_sync),
        .rd_in    (rd_shared),
        .wr_in    (wr_data),
        .rd_clint (rd_clint),
        .wr_clint (wr_clint),
        .rd_ext   (rd_ext),
        .wr_ext   (wr_ext)
    );

    clint_timer #(
        .TICK_DIV (TICK_DIV)
    ) i_clint_timer (
        .clock     (clock),
        .reset     (rst_sync),
        .rd        (rd_clint),
        .wr        (wr_clint),
        .timer_irq (timer_irq)
    );

endmodule

//--- tests/tb_fabric.sv
`timescale 1ns/1ps

module tb_fabric;

    localparam int          MAX_TESTS     = 32;
    localparam logic [31:0] CLINT_BASE    = 32'h0200_0000;
    localparam logic [31:0] CLINT_MASK    = 32'hFFFF_0000;
    localparam logic [63:0] UNWRITTEN_XOR = 64'hA5A5_0000_0000_0000;

    logic        clock;
    logic        reset;
    logic        timer_irq;
    logic        fetch_arvalid, fetch_rready, fetch_arready, fetch_rvalid;
    logic [31:0] fetch_araddr;
    logic [63:0] fetch_rdata;
    logic [1:0]  fetch_rresp;
    logic        data_arvalid, data_rready, data_arready, data_rvalid;
    logic [31:0] data_araddr, data_awaddr;
    logic [63:0] data_rdata, data_wdata;
    logic [1:0]  data_rresp, data_bresp;
    logic        data_awvalid, data_wvalid, data_bready;
    logic        data_awready, data_wready, data_bvalid;
    logic [7:0]  data_wstrb, mem_wstrb;
    logic        mem_arready, mem_rvalid, mem_awready, mem_wready, mem_bvalid;
    logic [63:0] mem_rdata, mem_wdata;
    logic [1:0]  mem_rresp, mem_bresp;
    logic        mem_arvalid, mem_rready, mem_awvalid, mem_wvalid, mem_bready;
    logic [31:0] mem_araddr, mem_awaddr;

    logic [63:0] golden [0:5*MAX_TESTS-1];
    logic [63:0] mem_model [logic [31:0]];
    logic [31:0] ar_log [$];
    int          num_tests;
    int          errors;
    int          leak_errors;

    fabric_top #(.TICK_DIV(1)) i_fabric_top (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic int random_delay(inout logic [31:0] state);
        state = state ^ (state << 13);
        state = state ^ (state >> 17);
        state = state ^ (state << 5);
        return int'(state % 32'd4);
    endfunction

    // Unwritten locations read as their own address with a marker on top
    function automatic logic [63:0] mem_value(input logic [31:0] a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return {32'h0, a} ^ UNWRITTEN_XOR;
    endfunction

    function automatic logic [63:0] merge_strobe(input logic [63:0] old_v, new_v,
                                                 input logic [7:0] s);
        logic [63:0] r;
        r = old_v;
        for (int i = 0; i < 8; i++) begin
            if (s[i]) begin
                r[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return r;
    endfunction

    function automatic string op_name(input int op);
        case (op)
            0:       return "fetch read";
            1:       return "data read";
            2:       return "data write";
            3:       return "dual read";
            4:       return "irq wait";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_read(input string what, input logic [63:0] got, exp,
                              input logic [1:0] resp);
        assert (got === exp && resp == 2'b00) else begin
            $display("ERROR at %0t: %s got %h resp %0d, expected %h resp 0",
                     $time, what, got, resp, exp);
            errors++;
        end
    endtask

    task automatic read_fetch(input logic [31:0] a, output logic [63:0] d,
                              output logic [1:0] r);
        @(negedge clock);
        fetch_arvalid = 1'b1;
        fetch_araddr  = a;
        @(posedge clock);
        while (fetch_arready !== 1'b1) @(posedge clock);
        @(negedge clock);
        fetch_arvalid = 1'b0;
        fetch_rready  = 1'b1;
        @(posedge clock);
        while (fetch_rvalid !== 1'b1) @(posedge clock);
        d = fetch_rdata;
        r = fetch_rresp;
        @(negedge clock);
        fetch_rready = 1'b0;
    endtask

    task automatic read_data(input logic [31:0] a, output logic [63:0] d,
                             output logic [1:0] r);
        @(negedge clock);
        data_arvalid = 1'b1;
        data_araddr  = a;
        @(posedge clock);
        while (data_arready !== 1'b1) @(posedge clock);
        @(negedge clock);
        data_arvalid = 1'b0;
        data_rready  = 1'b1;
        @(posedge clock);
        while (data_rvalid !== 1'b1) @(posedge clock);
        d = data_rdata;
        r = data_rresp;
        @(negedge clock);
        data_rready = 1'b0;
    endtask

    task automatic write_data(input logic [31:0] a, input logic [63:0] d,
                              input logic [7:0] s, output logic [1:0] r);
        logic aw_ok;
        logic w_ok;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        @(negedge clock);
        data_awvalid = 1'b1;
        data_awaddr  = a;
        data_wvalid  = 1'b1;
        data_wdata   = d;
        data_wstrb   = s;
        // AW and W may finish in either order
        while (!(aw_ok && w_ok)) begin
            @(posedge clock);
            if (data_awvalid && data_awready === 1'b1) begin
                aw_ok = 1'b1;
            end
            if (data_wvalid && data_wready === 1'b1) begin
                w_ok = 1'b1;
            end
            @(negedge clock);
            data_awvalid = data_awvalid && !aw_ok;
            data_wvalid  = data_wvalid && !w_ok;
        end
        data_bready = 1'b1;
        @(posedge clock);
        while (data_bvalid !== 1'b1) @(posedge clock);
        r = data_bresp;
        @(negedge clock);
        data_bready = 1'b0;
    endtask

    // Read side of the external memory
    initial begin : read_responder
        logic [31:0] ra;
        logic [31:0] rng;
        rng         = 32'd48;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rresp   = 2'b00;
        forever begin
            @(posedge clock);
            if (mem_arvalid === 1'b1) begin
                ra = mem_araddr;
                ar_log.push_back(ra);
                @(negedge clock);
                repeat (random_delay(rng)) @(negedge clock);
                mem_arready = 1'b1;
                @(posedge clock);
                @(negedge clock);
                mem_arready = 1'b0;
                repeat (random_delay(rng)) @(negedge clock);
                mem_rvalid = 1'b1;
                mem_rdata  = mem_value(ra);
                @(posedge clock);
                while (mem_rready !== 1'b1) @(posedge clock);
                @(negedge clock);
                mem_rvalid = 1'b0;
            end
        end
    end

    // Write side of the external memory
    initial begin : write_responder
        logic [31:0] wa;
        logic [31:0] rng;
        rng         = 32'd48;
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        mem_bresp   = 2'b00;
        forever begin
            @(posedge clock);
            if (mem_awvalid === 1'b1) begin
                wa = mem_awaddr;
                @(negedge clock);
                repeat (random_delay(rng)) @(negedge clock);
                mem_awready = 1'b1;
                @(posedge clock);
                @(negedge clock);
                mem_awready = 1'b0;
                @(posedge clock);
                while (mem_wvalid !== 1'b1) @(posedge clock);
                @(negedge clock);
                repeat (random_delay(rng)) @(negedge clock);
                mem_wready = 1'b1;
                @(posedge clock);
                mem_model[wa] = merge_strobe(mem_value(wa), mem_wdata, mem_wstrb);
                @(negedge clock);
                mem_wready = 1'b0;
                repeat (random_delay(rng)) @(negedge clock);
                mem_bvalid = 1'b1;
                @(posedge clock);
                while (mem_bready !== 1'b1) @(posedge clock);
                @(negedge clock);
                mem_bvalid = 1'b0;
            end
        end
    end

    // CLINT traffic must stay off the external bus
    always @(posedge clock) begin
        if (!reset && mem_arvalid === 1'b1) begin
            assert ((mem_araddr & CLINT_MASK) != CLINT_BASE) else begin
                $display("ERROR at %0t: CLINT read %h leaked to mem_", $time, mem_araddr);
                leak_errors++;
            end
        end
        if (!reset && mem_awvalid === 1'b1) begin
            assert ((mem_awaddr & CLINT_MASK) != CLINT_BASE) else begin
                $display("ERROR at %0t: CLINT write %h leaked to mem_", $time, mem_awaddr);
                leak_errors++;
            end
        end
        if (!reset && mem_wvalid === 1'b1) begin
            assert ((data_awaddr & CLINT_MASK) != CLINT_BASE) else begin
                $display("ERROR at %0t: CLINT write data for %h leaked to mem_", $time,
                         data_awaddr);
                leak_errors++;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        int limit;
        cycles = 0;
        @(posedge clock);
        limit = 60 * num_tests + 200;
        while (cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        logic [63:0] rd_val;
        logic [63:0] rd_val2;
        logic [1:0]  resp;
        logic [1:0]  resp2;
        logic [63:0] addr;
        logic [63:0] aux;
        logic [63:0] wdat;
        logic [63:0] expv;
        int          op;
        int          errs_before;
        int          passed;
        int          log_start;
        int          wait_cycles;
        reset         = 1'b1;
        errors        = 0;
        leak_errors   = 0;
        passed        = 0;
        fetch_arvalid = 1'b0;
        fetch_araddr  = '0;
        fetch_rready  = 1'b0;
        data_arvalid  = 1'b0;
        data_araddr   = '0;
        data_rready   = 1'b0;
        data_awvalid  = 1'b0;
        data_awaddr   = '0;
        data_wvalid   = 1'b0;
        data_wdata    = '0;
        data_wstrb    = '0;
        data_bready   = 1'b0;
        for (int i = 0; i < 5 * MAX_TESTS; i++) begin
            golden[i] = '1;
        end
        $readmemh("tests/fabric_golden.txt", golden);
        num_tests = 0;
        while (num_tests < MAX_TESTS && golden[5*num_tests] !== '1) begin
            num_tests++;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        if (num_tests == 0) begin
            $display("No operations were found in tests/fabric_golden.txt");
            errors++;
        end

        for (int t = 0; t < num_tests; t++) begin
            op          = int'(golden[5*t]);
            addr        = golden[5*t+1];
            aux         = golden[5*t+2];
            wdat        = golden[5*t+3];
            expv        = golden[5*t+4];
            errs_before = errors + leak_errors;
            case (op)
                0: begin
                    read_fetch(addr[31:0], rd_val, resp);
                    check_read("fetch port", rd_val, expv, resp);
                end
                1: begin
                    read_data(addr[31:0], rd_val, resp);
                    check_read("data port", rd_val, expv, resp);
                end
                2: begin
                    write_data(addr[31:0], wdat, aux[7:0], resp);
                    assert (resp == 2'b00) else begin
                        $display("ERROR at %0t: write to %h got bresp %0d", $time, addr, resp);
                        errors++;
                    end
                end
                3: begin
                    log_start = ar_log.size();
                    fork
                        read_data(addr[31:0], rd_val, resp);
                        read_fetch(aux[31:0], rd_val2, resp2);
                    join
                    check_read("data port", rd_val, wdat, resp);
                    check_read("fetch port", rd_val2, expv, resp2);
                    assert (ar_log.size() > log_start && ar_log[log_start] == addr[31:0])
                    else begin
                        $display("ERROR at %0t: data address was not first on mem_araddr",
                                 $time);
                        errors++;
                    end
                end
                4: begin
                    read_data(addr[31:0], rd_val, resp);
                    read_data(addr[31:0], rd_val2, resp2);
                    assert (rd_val2 >= rd_val && resp == 2'b00 && resp2 == 2'b00) else begin
                        $display("ERROR at %0t: mtime read %h then %h", $time, rd_val, rd_val2);
                        errors++;
                    end
                    write_data(aux[31:0], rd_val + wdat, 8'hFF, resp);
                    @(posedge clock);
                    assert (timer_irq == 1'b0) else begin
                        $display("ERROR at %0t: timer_irq high right after mtimecmp write",
                                 $time);
                        errors++;
                    end
                    wait_cycles = 0;
                    while (timer_irq !== 1'b1 && wait_cycles < int'(expv)) begin
                        @(posedge clock);
                        wait_cycles++;
                    end
                    assert (timer_irq === 1'b1) else begin
                        $display("ERROR at %0t: timer_irq not raised within %0d cycles",
                                 $time, int'(expv));
                        errors++;
                    end
                end
                default: begin
                    $display("Golden line %0d holds unknown operation code %0d", t, op);
                    errors++;
                end
            endcase
            if (errors + leak_errors == errs_before) begin
                passed++;
            end
            $display("test %0d (%s %h): %s", t, op_name(op), addr[31:0],
                     (errors + leak_errors == errs_before) ? "ok" : "failed");
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 num_tests, passed, num_tests - passed, errors + leak_errors);
        if (errors + leak_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- tests/fabric_golden.txt
// op addr aux data expected, hex. op 0 fetch read, 1 data read, 2 data write (aux = wstrb)
// 3 dual read (addr data port, aux fetch port, data/expected per port), 4 irq wait (aux mtimecmp)
0 80000000 0 0 A5A5000080000000
0 80000010 0 0 A5A5000080000010
2 80000100 0F 1122334455667788 0
2 80000100 F0 DEADBEEF00000000 0
1 80000100 0 0 DEADBEEF55667788
2 80000200 FF 0123456789ABCDEF 0
0 80000200 0 0 0123456789ABCDEF
3 80000300 80000400 A5A5000080000300 A5A5000080000400
2 02004000 FF 0000000012345678 0
1 02004000 0 0 0000000012345678
2 02004000 0F FFFFFFFFAAAABBBB 0
1 02004000 0 0 00000000AAAABBBB
1 02000008 0 0 0
4 0200BFF8 02004000 C8 190

//--- tb.f
src/fabric_pkg.sv
src/rd_bus_if.sv
src/wr_bus_if.sv
src/read_arbiter.sv
src/addr_router.sv
src/clint_timer.sv
src/fabric_top.sv
tests/tb_fabric.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert --top-module tb_fabric -f tb.f -o tb_fabric_sim > build.log 2>&1 \
    && ./obj_dir/tb_fabric_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
